/* source/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // Geometry
    localparam int addr_w     = 15;
    localparam int tag_w      = 9;
    localparam int set_w      = 2;
    localparam int num_sets   = 4;
    localparam int num_ways   = 4;
    localparam int line_bytes = 16;
    localparam int line_w     = 128;
    localparam int beat_w     = 32;
    localparam int num_beats  = 4;

    // Derived index widths
    localparam int offset_w   = $clog2(line_bytes);
    localparam int way_w      = $clog2(num_ways);
    localparam int beat_idx_w = $clog2(num_beats);

    typedef enum logic [2:0] {
        idle,
        lookup,
        wb_req,
        wb_data,
        fill_req,
        fill_data,
        respond
    } cache_state_t;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_t;

endpackage

`default_nettype wire

/* source/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [cache_pkg::set_w-1:0]    set,
    input  logic [cache_pkg::tag_w-1:0]    tag,
    input  logic [cache_pkg::way_w-1:0]    way,
    input  logic                           tag_we,
    input  logic [cache_pkg::way_w-1:0]    victim_way,
    output logic                           hit,
    output logic [cache_pkg::way_w-1:0]    hit_way,
    output logic [cache_pkg::tag_w-1:0]    victim_tag_of,
    output logic [cache_pkg::num_ways-1:0] valid_bits
);
    import cache_pkg::*;

    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [tag_w-1:0]                  tags [num_sets][num_ways];
    logic [num_ways-1:0]               match;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (tag_we) begin
            valid_q[set][way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[set][way] <= tag;
        end
    end

    // Four-way compare on the registered set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid_q[set][w] && (tags[set][w] == tag);
        end
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_w'(w);
            end
        end
    end

    assign hit           = |match;
    assign valid_bits    = valid_q[set];
    assign victim_tag_of = tags[set][victim_way];

endmodule

`default_nettype wire

/* source/meta_store.sv */
`timescale 1ns/1ps
`default_nettype none

module meta_store (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [cache_pkg::set_w-1:0]    set,
    input  logic [cache_pkg::way_w-1:0]    way,
    input  logic                           touch,
    input  logic                           mark_dirty,
    input  logic                           clear_dirty,
    input  logic [cache_pkg::num_ways-1:0] valid_bits,
    output logic [cache_pkg::way_w-1:0]    victim_way,
    output logic                           victim_dirty
);
    import cache_pkg::*;

    logic [num_sets-1:0][num_ways-1:0]            dirty_q;
    logic [num_sets-1:0][num_ways-1:0][way_w-1:0] age_q;
    logic [way_w-1:0]                             touched_age;
    logic                                         any_invalid;
    logic [way_w-1:0]                             invalid_way;
    logic [way_w-1:0]                             oldest_way;

    // A way filled from invalid counts as oldest, so valid ways keep distinct ages
    assign touched_age = valid_bits[way] ? age_q[set][way] : way_w'(num_ways - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            age_q <= '0;
        end else if (touch) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_w'(w) == way) begin
                    age_q[set][w] <= '0;
                end else if (valid_bits[w] && (age_q[set][w] < touched_age)) begin
                    age_q[set][w] <= age_q[set][w] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dirty_q <= '0;
        end else if (touch) begin
            if (mark_dirty) begin
                dirty_q[set][way] <= 1'b1;
            end else if (clear_dirty) begin
                dirty_q[set][way] <= 1'b0;
            end
        end
    end

    // Lowest invalid way wins, else the oldest
    always_comb begin
        any_invalid = 1'b0;
        invalid_way = '0;
        oldest_way  = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_bits[w]) begin
                any_invalid = 1'b1;
                invalid_way = way_w'(w);
            end
            if (age_q[set][w] == way_w'(num_ways - 1)) begin
                oldest_way = way_w'(w);
            end
        end
    end

    assign victim_way   = any_invalid ? invalid_way : oldest_way;
    assign victim_dirty = valid_bits[victim_way] && dirty_q[set][victim_way];

endmodule

`default_nettype wire

/* source/data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  logic                             clk,
    input  logic [cache_pkg::set_w-1:0]      set,
    input  logic [cache_pkg::way_w-1:0]      way,
    input  logic [cache_pkg::way_w-1:0]      victim_way,
    input  logic                             line_we,
    input  logic [cache_pkg::line_w-1:0]     wdata,
    input  logic [cache_pkg::line_bytes-1:0] mask,
    input  logic                             fill_we,
    input  logic [cache_pkg::beat_idx_w-1:0] beat_idx,
    input  logic [cache_pkg::beat_w-1:0]     fill_data,
    output logic [cache_pkg::line_w-1:0]     line,
    output logic [cache_pkg::line_w-1:0]     victim_line
);
    import cache_pkg::*;

    logic [line_w-1:0] lines [num_sets][num_ways];

    // Masked bytes land after the refill beat on the same edge
    always_ff @(posedge clk) begin
        if (fill_we) begin
            lines[set][way][beat_idx*beat_w +: beat_w] <= fill_data;
        end
        if (line_we) begin
            for (int b = 0; b < line_bytes; b++) begin
                if (mask[b]) begin
                    lines[set][way][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    assign line        = lines[set][way];
    assign victim_line = lines[set][victim_way];

endmodule

`default_nettype wire

/* source/beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             start,
    input  logic                             advance,
    output logic [cache_pkg::beat_idx_w-1:0] beat_idx,
    output logic                             last
);
    import cache_pkg::*;

    logic [beat_idx_w-1:0] count_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (start) begin
            count_q <= '0;
        end else if (advance) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign beat_idx = count_q;
    // High for the whole of the final beat
    assign last     = (count_q == beat_idx_w'(num_beats - 1));

endmodule

`default_nettype wire

/* source/miss_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_fsm (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     req_valid,
    input  logic                                     req_write,
    input  logic [cache_pkg::addr_w-1:0]             req_addr,
    input  logic [cache_pkg::line_w-1:0]             req_wdata,
    input  logic [cache_pkg::line_bytes-1:0]         req_mask,
    input  logic                                     rsp_ready,
    input  logic                                     mem_req_ready,
    input  logic                                     mem_rsp_valid,
    input  logic [cache_pkg::way_w-1:0]              hit_way,
    input  logic                                     hit,
    input  logic [cache_pkg::way_w-1:0]              victim_way,
    input  logic                                     victim_dirty,
    input  logic [cache_pkg::tag_w-1:0]              victim_tag,
    input  logic                                     beat_last,
    output logic                                     req_ready,
    output logic                                     rsp_valid,
    output logic                                     rsp_hit,
    output logic                                     mem_req_valid,
    output cache_pkg::mem_op_t                       mem_req_op,
    output logic [cache_pkg::tag_w+cache_pkg::set_w-1:0] mem_req_addr,
    output logic [cache_pkg::set_w-1:0]              cur_set,
    output logic [cache_pkg::tag_w-1:0]              cur_tag,
    output logic [cache_pkg::way_w-1:0]              cur_way,
    output logic [cache_pkg::line_w-1:0]             cur_wdata,
    output logic [cache_pkg::line_bytes-1:0]         cur_mask,
    output logic                                     tag_we,
    output logic                                     data_merge_we,
    output logic                                     fill_we,
    output logic                                     touch,
    output logic                                     beat_start,
    output logic                                     beat_advance
);
    import cache_pkg::*;

    cache_state_t          state_q;
    cache_state_t          state_d;
    logic                  write_q;
    logic                  hit_q;
    logic [way_w-1:0]      way_q;
    logic [set_w-1:0]      set_q;
    logic [tag_w-1:0]      tag_q;
    logic [line_w-1:0]     wdata_q;
    logic [line_bytes-1:0] mask_q;
    logic                  req_fire;
    logic                  mem_fire;
    logic                  fill_beat;
    logic                  fill_done;

    assign req_fire  = req_valid && req_ready;
    assign mem_fire  = mem_req_valid && mem_req_ready;
    assign fill_beat = (state_q == fill_data) && mem_rsp_valid;
    assign fill_done = fill_beat && beat_last;

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:      if (req_valid) state_d = lookup;
            lookup: begin
                if (hit) begin
                    state_d = respond;
                end else if (victim_dirty) begin
                    state_d = wb_req;
                end else begin
                    state_d = fill_req;
                end
            end
            wb_req:    state_d = wb_data;
            wb_data:   if (mem_fire && beat_last) state_d = fill_req;
            fill_req:  if (mem_fire) state_d = fill_data;
            fill_data: if (fill_done) state_d = respond;
            respond:   if (rsp_ready) state_d = idle;
            default:   state_d = idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= idle;
            write_q <= 1'b0;
            hit_q   <= 1'b0;
            way_q   <= '0;
        end else begin
            state_q <= state_d;
            if (req_fire) begin
                write_q <= req_write;
            end
            if (state_q == lookup) begin
                hit_q <= hit;
                way_q <= hit ? hit_way : victim_way;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            set_q   <= req_addr[offset_w +: set_w];
            tag_q   <= req_addr[addr_w-1 -: tag_w];
            wdata_q <= req_wdata;
            mask_q  <= req_mask;
        end
    end

    assign req_ready     = (state_q == idle);
    assign rsp_valid     = (state_q == respond);
    assign rsp_hit       = hit_q;

    assign mem_req_valid = (state_q == wb_data) || (state_q == fill_req);
    assign mem_req_op    = (state_q == wb_data) ? mem_write : mem_read;
    assign mem_req_addr  = (state_q == wb_data) ? {victim_tag, set_q} : {tag_q, set_q};

    assign cur_set   = set_q;
    assign cur_tag   = tag_q;
    assign cur_way   = (state_q == lookup) ? (hit ? hit_way : victim_way) : way_q;
    assign cur_wdata = wdata_q;
    assign cur_mask  = mask_q;

    // Hit in lookup, or the refill has just completed
    assign touch         = ((state_q == lookup) && hit) || fill_done;
    assign tag_we        = fill_done;
    assign fill_we       = fill_beat;
    assign data_merge_we = write_q && touch;

    assign beat_start   = (state_q == wb_req) || ((state_q == fill_req) && mem_fire);
    assign beat_advance = ((state_q == wb_data) && mem_fire) || fill_beat;

endmodule

`default_nettype wire

/* source/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         req_valid,
    output logic                                         req_ready,
    input  logic                                         req_write,
    input  logic [cache_pkg::addr_w-1:0]                 req_addr,
    input  logic [cache_pkg::line_w-1:0]                 req_wdata,
    input  logic [cache_pkg::line_bytes-1:0]             req_mask,
    output logic                                         rsp_valid,
    input  logic                                         rsp_ready,
    output logic [cache_pkg::line_w-1:0]                 rsp_data,
    output logic                                         rsp_hit,
    output logic                                         mem_req_valid,
    input  logic                                         mem_req_ready,
    output cache_pkg::mem_op_t                           mem_req_op,
    output logic [cache_pkg::tag_w+cache_pkg::set_w-1:0] mem_req_addr,
    output logic [cache_pkg::beat_w-1:0]                 mem_wdata,
    input  logic                                         mem_rsp_valid,
    input  logic [cache_pkg::beat_w-1:0]                 mem_rsp_data
);
    import cache_pkg::*;

    logic                  hit;
    logic [way_w-1:0]      hit_way;
    logic [way_w-1:0]      victim_way;
    logic                  victim_dirty;
    logic [tag_w-1:0]      victim_tag;
    logic [num_ways-1:0]   valid_bits;
    logic [set_w-1:0]      cur_set;
    logic [tag_w-1:0]      cur_tag;
    logic [way_w-1:0]      cur_way;
    logic [line_w-1:0]     cur_wdata;
    logic [line_bytes-1:0] cur_mask;
    logic                  tag_we;
    logic                  data_merge_we;
    logic                  fill_we;
    logic                  touch;
    logic                  beat_start;
    logic                  beat_advance;
    logic [beat_idx_w-1:0] beat_idx;
    logic                  beat_last;
    logic [line_w-1:0]     victim_line;

    miss_fsm u_fsm (
        .clk, .arst_n,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_mask,
        .rsp_ready, .mem_req_ready, .mem_rsp_valid,
        .hit_way, .hit, .victim_way, .victim_dirty, .victim_tag, .beat_last,
        .req_ready, .rsp_valid, .rsp_hit,
        .mem_req_valid, .mem_req_op, .mem_req_addr,
        .cur_set, .cur_tag, .cur_way, .cur_wdata, .cur_mask,
        .tag_we, .data_merge_we, .fill_we, .touch, .beat_start, .beat_advance
    );

    tag_store u_tags (
        .clk, .arst_n,
        .set           (cur_set),
        .tag           (cur_tag),
        .way           (cur_way),
        .tag_we,
        .victim_way,
        .hit,
        .hit_way,
        .victim_tag_of (victim_tag),
        .valid_bits
    );

    // Refill clears dirty unless the write merges on the same edge
    meta_store u_meta (
        .clk, .arst_n,
        .set         (cur_set),
        .way         (cur_way),
        .touch,
        .mark_dirty  (data_merge_we),
        .clear_dirty (tag_we),
        .valid_bits,
        .victim_way,
        .victim_dirty
    );

    data_store u_data (
        .clk,
        .set         (cur_set),
        .way         (cur_way),
        .victim_way,
        .line_we     (data_merge_we),
        .wdata       (cur_wdata),
        .mask        (cur_mask),
        .fill_we,
        .beat_idx,
        .fill_data   (mem_rsp_data),
        .line        (rsp_data),
        .victim_line
    );

    beat_counter u_beats (
        .clk, .arst_n,
        .start    (beat_start),
        .advance  (beat_advance),
        .beat_idx,
        .last     (beat_last)
    );

    // Writeback word, beat 0 is the low word
    assign mem_wdata = victim_line[beat_idx*beat_w +: beat_w];

endmodule

`default_nettype wire

/* tb/cache_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_assert (
    input logic                                         clk,
    input logic                                         arst_n,
    input logic                                         rsp_valid,
    input logic                                         rsp_ready,
    input logic [cache_pkg::line_w-1:0]                 rsp_data,
    input logic                                         rsp_hit,
    input logic                                         mem_req_valid,
    input logic                                         mem_req_ready,
    input cache_pkg::mem_op_t                           mem_req_op,
    input logic [cache_pkg::tag_w+cache_pkg::set_w-1:0] mem_req_addr,
    input logic [cache_pkg::beat_w-1:0]                 mem_wdata,
    input cache_pkg::cache_state_t                      state
);
    import cache_pkg::*;

    int fail_count = 0;

    // Response stays up with stable data until accepted
    rsp_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_hit))
        else begin
            $error("response dropped or changed while stalled");
            fail_count++;
        end

    mem_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_op)
            && $stable(mem_req_addr) && $stable(mem_wdata))
        else begin
            $error("memory request dropped or changed while stalled");
            fail_count++;
        end

    // Refill goes to the requested line, not back to the victim
    refill_after_wb: assert property (@(posedge clk) disable iff (!arst_n)
        (state == fill_req) && ($past(state) == wb_data)
            |-> mem_req_addr != $past(mem_req_addr))
        else begin
            $error("refill addresses the line that was just written back");
            fail_count++;
        end

endmodule

bind cache_top cache_assert u_assert (
    .clk, .arst_n, .rsp_valid, .rsp_ready, .rsp_data, .rsp_hit,
    .mem_req_valid, .mem_req_ready, .mem_req_op, .mem_req_addr, .mem_wdata,
    .state (u_fsm.state_q)
);

`default_nettype wire

/* tb/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int wait_limit = 400;

    typedef logic [tag_w+set_w-1:0] line_addr_t;

    typedef struct packed {
        logic                  write;
        logic [tag_w-1:0]      tag;
        logic [set_w-1:0]      set;
        logic [line_w-1:0]     wdata;
        logic [line_bytes-1:0] mask;
        logic                  hit;
        logic                  wb;
        logic [3:0]            hold;
    } row_t;

    logic                  clk;
    logic                  arst_n;
    logic                  req_valid;
    logic                  req_ready;
    logic                  req_write;
    logic [addr_w-1:0]     req_addr;
    logic [line_w-1:0]     req_wdata;
    logic [line_bytes-1:0] req_mask;
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [line_w-1:0]     rsp_data;
    logic                  rsp_hit;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    mem_op_t               mem_req_op;
    line_addr_t            mem_req_addr;
    logic [beat_w-1:0]     mem_wdata;
    logic                  mem_rsp_valid;
    logic [beat_w-1:0]     mem_rsp_data;

    logic [7:0]  shadow [2**addr_w];
    logic [7:0]  backing [2**addr_w];
    logic [31:0] lfsr;
    row_t        rows [$];
    mem_op_t     op_log [$];
    string       cur_name;
    line_addr_t  cur_line;
    logic        timed_out = 1'b0;
    int          err_data = 0;
    int          err_hit = 0;
    int          err_op = 0;
    int          err_count = 0;
    int          err_addr = 0;
    int          err_other = 0;

    cache_top cache_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hd000_0001;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [line_w-1:0] shadow_line(input line_addr_t line_addr);
        logic [line_w-1:0] v;
        for (int b = 0; b < line_bytes; b++) begin
            v[b*8 +: 8] = shadow[{line_addr, offset_w'(b)}];
        end
        return v;
    endfunction

    function automatic logic [beat_w-1:0] backing_word(input line_addr_t line_addr, input int beat);
        logic [beat_w-1:0] v;
        for (int b = 0; b < beat_w / 8; b++) begin
            v[b*8 +: 8] = backing[{line_addr, offset_w'(beat * 4 + b)}];
        end
        return v;
    endfunction

    task automatic check_line(input string name, input logic [line_w-1:0] exp,
                              input logic [line_w-1:0] act);
        if (act !== exp) begin
            err_data++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_hit++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input mem_op_t exp, input mem_op_t act);
        if (act !== exp) begin
            err_op++;
            $display("ERR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input line_addr_t exp, input line_addr_t act);
        if (act !== exp) begin
            err_addr++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            err_count++;
            $display("ERR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic add_row(input logic write, input logic [tag_w-1:0] tag,
                           input logic [set_w-1:0] set, input logic [line_w-1:0] wdata,
                           input logic [line_bytes-1:0] mask, input logic hit,
                           input logic wb, input int hold);
        row_t r;
        r.write = write;
        r.tag   = tag;
        r.set   = set;
        r.wdata = wdata;
        r.mask  = mask;
        r.hit   = hit;
        r.wb    = wb;
        r.hold  = 4'(hold);
        rows.push_back(r);
    endtask

    // op, tag, set, wdata, mask, hit, writeback, rsp_ready stall
    task automatic build_table();
        add_row(0, 9'h010, 2'd1, '0, '0, 0, 0, 0);
        add_row(0, 9'h011, 2'd1, '0, '0, 0, 0, 0);
        add_row(0, 9'h012, 2'd1, '0, '0, 0, 0, 0);
        add_row(0, 9'h013, 2'd1, '0, '0, 0, 0, 0);
        add_row(0, 9'h010, 2'd1, '0, '0, 1, 0, 0);
        add_row(0, 9'h011, 2'd1, '0, '0, 1, 0, 2);
        add_row(1, 9'h012, 2'd1, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 16'h00f0, 1, 0, 0);
        add_row(1, 9'h013, 2'd1, 128'hdead_beef_0000_1111_2222_3333_cafe_f00d, 16'h8001, 1, 0, 0);
        add_row(0, 9'h012, 2'd1, '0, '0, 1, 0, 0);
        // LRU now points at clean ways, then at the two dirty ones
        add_row(0, 9'h014, 2'd1, '0, '0, 0, 0, 0);
        add_row(1, 9'h015, 2'd1, 128'h5a5a_a5a5_1234_5678_9abc_def0_0f0f_f0f0, 16'h3c3c, 0, 0, 0);
        add_row(0, 9'h016, 2'd1, '0, '0, 0, 1, 3);
        add_row(0, 9'h017, 2'd1, '0, '0, 0, 1, 2);
        add_row(0, 9'h013, 2'd1, '0, '0, 0, 0, 0);
        add_row(0, 9'h015, 2'd1, '0, '0, 1, 0, 0);
        add_row(1, 9'h020, 2'd2, 128'h8888_7777_6666_5555_4444_3333_2222_1111, 16'h0f0f, 0, 0, 1);
        add_row(0, 9'h020, 2'd2, '0, '0, 1, 0, 0);
        add_row(0, 9'h010, 2'd1, '0, '0, 0, 0, 0);
        add_row(1, 9'h015, 2'd1, 128'hffee_ddcc_bbaa_9988_7766_5544_3322_1100, 16'hff00, 1, 0, 2);
        add_row(0, 9'h018, 2'd1, '0, '0, 0, 0, 0);
    endtask

    // Memory model with random ready stalls and refill gaps
    initial begin
        logic [line_w-1:0] wb_line;
        line_addr_t        wb_addr;
        line_addr_t        fill_addr;
        int                wb_count;
        int                fill_beat;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        wb_count      = 0;
        fill_beat     = num_beats;
        forever begin
            @(posedge clk);
            if (arst_n && mem_req_valid && mem_req_ready) begin
                op_log.push_back(mem_req_op);
                if (mem_req_op == mem_write) begin
                    if (wb_count == 0) begin
                        wb_addr = mem_req_addr;
                    end
                    wb_line[wb_count*beat_w +: beat_w] = mem_wdata;
                    wb_count++;
                    if (wb_count == num_beats) begin
                        check_line({cur_name, " writeback"}, shadow_line(wb_addr), wb_line);
                        for (int b = 0; b < line_bytes; b++) begin
                            backing[{wb_addr, offset_w'(b)}] = wb_line[b*8 +: 8];
                        end
                        wb_count = 0;
                    end
                end else begin
                    check_addr({cur_name, " refill address"}, cur_line, mem_req_addr);
                    fill_addr = mem_req_addr;
                    fill_beat = 0;
                end
            end
            mem_req_ready <= (rand_bits(2) != 0);
            if (fill_beat < num_beats && next_bit()) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= backing_word(fill_addr, fill_beat);
                fill_beat++;
            end else begin
                mem_rsp_valid <= 1'b0;
            end
        end
    end

    task automatic run_row(input int i);
        row_t              r;
        string             name;
        logic [line_w-1:0] exp_line;
        int                cyc;
        int                hold;
        r        = rows[i];
        name     = $sformatf("row%0d", i);
        hold     = r.hold;
        cur_name = name;
        cur_line = {r.tag, r.set};
        op_log.delete();
        req_valid <= 1'b1;
        req_write <= r.write;
        req_addr  <= {r.tag, r.set, offset_w'(i)};
        req_wdata <= r.wdata;
        req_mask  <= r.mask;
        rsp_ready <= (hold == 0);
        cyc = 0;
        do begin
            @(posedge clk);
            cyc++;
        end while (!(req_valid && req_ready) && cyc < wait_limit);
        if (!(req_valid && req_ready)) begin
            err_other++;
            timed_out = 1'b1;
            $display("%s: the cache never accepted the request", name);
        end else begin
            req_valid <= 1'b0;
            if (r.write) begin
                for (int b = 0; b < line_bytes; b++) begin
                    if (r.mask[b]) begin
                        shadow[{r.tag, r.set, offset_w'(b)}] = r.wdata[b*8 +: 8];
                    end
                end
            end
            exp_line = shadow_line({r.tag, r.set});
            cyc = 0;
            do begin
                @(posedge clk);
                cyc++;
            end while (!rsp_valid && cyc < wait_limit);
            if (!rsp_valid) begin
                err_other++;
                timed_out = 1'b1;
                $display("%s: no response arrived", name);
            end else begin
                check_line(name, exp_line, rsp_data);
                check_bit({name, " hit"}, r.hit, rsp_hit);
                if (r.hit) begin
                    check_count({name, " hit latency"}, 2, cyc);
                end
                cyc = 0;
                while (!(rsp_valid && rsp_ready) && cyc < wait_limit) begin
                    if (hold <= 1) begin
                        rsp_ready <= 1'b1;
                    end
                    hold--;
                    @(posedge clk);
                    cyc++;
                end
                if (!(rsp_valid && rsp_ready)) begin
                    err_other++;
                    timed_out = 1'b1;
                    $display("%s: the response was never accepted", name);
                end else begin
                    check_count({name, " memory requests"},
                                r.hit ? 0 : (r.wb ? num_beats + 1 : 1), op_log.size());
                    foreach (op_log[k]) begin
                        check_op({name, " memory op"},
                                 (r.wb && k < num_beats) ? mem_write : mem_read, op_log[k]);
                    end
                end
            end
        end
    endtask

    initial begin
        int total;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_mask  = '0;
        rsp_ready = 1'b1;
        cur_line  = '0;
        lfsr      = 32'hee84_883c;
        for (int a = 0; a < 2**addr_w; a++) begin
            shadow[a]  = rand_bits(8);
            backing[a] = shadow[a];
        end
        build_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_bit("reset req_ready", 1'b1, req_ready);
        check_bit("reset rsp_valid", 1'b0, rsp_valid);
        check_bit("reset mem_req_valid", 1'b0, mem_req_valid);
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            run_row(i);
        end
        total = err_data + err_hit + err_op + err_count + err_addr + err_other
              + cache_top_inst.u_assert.fail_count;
        $display("errors: data=%0d hit=%0d op=%0d count=%0d addr=%0d other=%0d assert=%0d",
                 err_data, err_hit, err_op, err_count, err_addr, err_other,
                 cache_top_inst.u_assert.fail_count);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/cache_pkg.sv
source/tag_store.sv
source/meta_store.sv
source/data_store.sv
source/beat_counter.sv
source/miss_fsm.sv
source/cache_top.sv
tb/cache_assert.sv
tb/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - files:
      - source/cache_pkg.sv
      - source/tag_store.sv
      - source/meta_store.sv
      - source/data_store.sv
      - source/beat_counter.sv
      - source/miss_fsm.sv
      - source/cache_top.sv
  - target: test
    files:
      - tb/cache_assert.sv
      - tb/cache_tb.sv
